//--- logic/mmio_pkg.sv
package mmio_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////////////////////

    // top nibble of the 30-bit word address
    localparam logic [3:0] region_vmem   = 4'hc;
    localparam logic [3:0] region_trap   = 4'hd;
    localparam logic [3:0] region_kbd    = 4'he;
    localparam logic [3:0] region_loader = 4'hf;

    // sub field inside region d that traps
    localparam logic [7:0] trap_sub = 8'hdd;

    // display write with this scroll field asks for a scroll
    localparam logic [3:0] scroll_sel = 4'hf;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int loader_aw        = 13;
    localparam int char_queue_depth = 8;
    localparam int key_queue_depth  = 8;
    localparam int char_ptr_w       = $clog2(char_queue_depth);
    localparam int key_ptr_w        = $clog2(key_queue_depth);

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    // generic device view of a data address
    typedef struct packed {
        logic [3:0]  region;
        logic [7:0]  sub;
        logic [17:0] word;
    } dev_addr_t;

    // display view of the same word
    typedef struct packed {
        logic [3:0]  region;
        logic [3:0]  scroll;
        logic [8:0]  pad;
        logic [12:0] char_word;
    } vmem_addr_t;

    typedef union packed {
        dev_addr_t  dev;
        vmem_addr_t vmem;
    } dmem_addr_u;

    // data access from the cpu
    typedef struct packed {
        logic        read;
        logic        write;
        dmem_addr_u  addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
    } dmem_req_t;

    // request toward the external data cache
    typedef struct packed {
        logic        read;
        logic        write;
        logic [3:0]  wen;
        logic [29:0] addr;
        logic [31:0] wdata;
    } dcache_req_t;

    // one character write for the text display
    typedef struct packed {
        logic        scroll;
        logic [14:0] addr;
        logic [7:0]  ch;
    } char_req_t;

endpackage

//--- logic/mmio_decoder.sv
module mmio_decoder (
    input  mmio_pkg::dmem_req_t   dmem,
    input  logic [29:0]           instr_addr,
    input  logic [31:0]           dc_rdata,
    input  logic [31:0]           ic_rdata,
    input  logic [31:0]           loader_rdata,
    input  logic [31:0]           loader_irdata,
    input  logic [7:0]            key_head,
    input  logic                  kb_ready,
    input  logic                  char_full,
    input  logic                  cache_stall,
    output mmio_pkg::dcache_req_t dcache,
    output logic                  ic_read,
    output logic [3:0]            loader_wen,
    output logic                  char_push,
    output mmio_pkg::char_req_t   char_req,
    output logic                  key_pop,
    output logic                  trap_stall,
    output logic                  mem_stall,
    output logic [31:0]           dmem_rdata,
    output logic [31:0]           instr_rdata
);

    mmio_pkg::dev_addr_t  dev;
    mmio_pkg::vmem_addr_t vmem;
    mmio_pkg::dev_addr_t  instr_dev;
    logic [3:0]           lane_wen;
    logic [1:0]           byte_ofs;

    // cpu byte lanes are numbered the other way round from memory lanes
    function automatic logic [3:0] swap_lanes(input logic [3:0] be);
        case (be)
            4'b0001: return 4'b1000;
            4'b0010: return 4'b0100;
            4'b0100: return 4'b0010;
            4'b1000: return 4'b0001;
            4'b0011: return 4'b1100;
            4'b1100: return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    assign dev       = dmem.addr.dev;
    assign vmem      = dmem.addr.vmem;
    assign instr_dev = instr_addr;
    assign lane_wen  = swap_lanes(dmem.byte_en);

    ////////////////////////////////////////////////////////////////////////////
    // data side routing
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        dcache.read  = 1'b0;
        dcache.write = 1'b0;
        dcache.wen   = 4'b0000;
        dcache.addr  = dmem.addr;
        dcache.wdata = dmem.wdata;
        loader_wen   = 4'b0000;
        char_push    = 1'b0;
        key_pop      = 1'b0;
        trap_stall   = 1'b0;
        dmem_rdata   = 32'd0;
        case (dev.region)
            mmio_pkg::region_vmem: begin
                char_push = dmem.write;
            end
            mmio_pkg::region_trap: begin
                // other region d reads just return zero
                if (dev.sub == mmio_pkg::trap_sub) begin
                    trap_stall = dmem.read | dmem.write;
                end
            end
            mmio_pkg::region_kbd: begin
                key_pop    = dmem.read;
                dmem_rdata = {24'd0, key_head};
            end
            mmio_pkg::region_loader: begin
                if (dmem.write) begin
                    loader_wen = lane_wen;
                end
                dmem_rdata = loader_rdata;
            end
            default: begin
                dcache.read  = dmem.read;
                dcache.write = dmem.write;
                dcache.wen   = lane_wen;
                dmem_rdata   = dc_rdata;
            end
        endcase
    end

    // display request, byte picked by the one-hot enable
    always_comb begin
        case (dmem.byte_en)
            4'b1000: begin
                byte_ofs    = 2'd0;
                char_req.ch = dmem.wdata[7:0];
            end
            4'b0100: begin
                byte_ofs    = 2'd1;
                char_req.ch = dmem.wdata[15:8];
            end
            4'b0010: begin
                byte_ofs    = 2'd2;
                char_req.ch = dmem.wdata[23:16];
            end
            default: begin
                byte_ofs    = 2'd3;
                char_req.ch = dmem.wdata[31:24];
            end
        endcase
        char_req.addr   = {vmem.char_word, byte_ofs};
        char_req.scroll = (vmem.scroll == mmio_pkg::scroll_sel);
    end

    // instruction fetch, region f comes from the loader
    assign ic_read     = (instr_dev.region != mmio_pkg::region_loader);
    assign instr_rdata = ic_read ? ic_rdata : loader_irdata;

    assign mem_stall = cache_stall
                     | (char_push & char_full)
                     | (key_pop & ~kb_ready)
                     | trap_stall;

endmodule

//--- logic/loader_ram.sv
module loader_ram (
    input  logic                           clk_pipeline,
    input  logic [mmio_pkg::loader_aw-1:0] a_addr,
    input  logic [31:0]                    a_wdata,
    input  logic [3:0]                     a_wen,
    output logic [31:0]                    a_rdata,
    input  logic [mmio_pkg::loader_aw-1:0] b_addr,
    output logic [31:0]                    b_rdata
);

    logic [31:0] mem [1 << mmio_pkg::loader_aw];

    // port a, data side with byte writes
    always_ff @(posedge clk_pipeline) begin
        for (int i = 0; i < 4; i++) begin
            if (a_wen[i]) begin
                mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
            end
        end
        a_rdata <= mem[a_addr];
    end

    // port b, instruction fetch only
    always_ff @(posedge clk_pipeline) begin
        b_rdata <= mem[b_addr];
    end

endmodule

//--- logic/char_request_queue.sv
module char_request_queue (
    input  logic                clk_pipeline,
    input  logic                rst,
    input  logic                push,
    input  mmio_pkg::char_req_t push_req,
    output logic                full,
    input  logic                take,
    output mmio_pkg::char_req_t head,
    output logic                valid
);

    mmio_pkg::char_req_t                entries [mmio_pkg::char_queue_depth];
    logic [mmio_pkg::char_ptr_w-1:0]    wr_ptr;
    logic [mmio_pkg::char_ptr_w-1:0]    rd_ptr;
    logic [mmio_pkg::char_ptr_w:0]      count;
    logic                               push_fire;
    logic                               take_fire;

    assign full      = (count == (mmio_pkg::char_ptr_w + 1)'(mmio_pkg::char_queue_depth));
    assign valid     = (count != '0);
    // a push while full waits, the cpu is stalled on it
    assign push_fire = push & ~full;
    assign take_fire = take & valid;
    assign head      = entries[rd_ptr];

    ////////////////////////////////////////////////////////////////////////////
    // pointers and fill level
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (take_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_fire, take_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_pipeline) begin
        if (push_fire) begin
            entries[wr_ptr] <= push_req;
        end
    end

endmodule

//--- logic/ps2_receiver.sv
module ps2_receiver (
    input  logic       clk_pipeline,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       key_strobe,
    output logic [7:0] key_code
);

    logic [1:0]  clk_sync;
    logic [1:0]  data_sync;
    logic        clk_prev;
    logic        clk_fall;
    logic [9:0]  shift;
    logic [3:0]  bit_cnt;
    logic [10:0] frame;
    logic        frame_ok;

    ////////////////////////////////////////////////////////////////////////////
    // synchronizers and edge detect
    ////////////////////////////////////////////////////////////////////////////

    // both lines idle high
    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];

    ////////////////////////////////////////////////////////////////////////////
    // frame assembly
    ////////////////////////////////////////////////////////////////////////////

    // lsb first, the stop bit is the bit arriving now
    assign frame    = {data_sync[1], shift};
    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            bit_cnt    <= 4'd0;
            key_strobe <= 1'b0;
        end else begin
            key_strobe <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= 4'd0;
                    key_strobe <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_pipeline) begin
        if (clk_fall && bit_cnt != 4'd10) begin
            shift <= {data_sync[1], shift[9:1]};
        end
        if (clk_fall && bit_cnt == 4'd10) begin
            key_code <= frame[8:1];
        end
    end

endmodule

//--- logic/scancode_queue.sv
module scancode_queue (
    input  logic       clk_pipeline,
    input  logic       rst,
    input  logic       key_strobe,
    input  logic [7:0] key_code,
    input  logic       pop,
    output logic [7:0] head,
    output logic       kb_ready,
    output logic       kb_overflow
);

    logic [7:0]                     codes [mmio_pkg::key_queue_depth];
    logic [mmio_pkg::key_ptr_w-1:0] wr_ptr;
    logic [mmio_pkg::key_ptr_w-1:0] rd_ptr;
    logic [mmio_pkg::key_ptr_w:0]   count;
    logic                           full;
    logic                           push_fire;
    logic                           pop_fire;

    assign full      = (count == (mmio_pkg::key_ptr_w + 1)'(mmio_pkg::key_queue_depth));
    assign kb_ready  = (count != '0);
    assign push_fire = key_strobe & ~full;
    assign pop_fire  = pop & kb_ready;
    assign head      = codes[rd_ptr];

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            kb_overflow <= 1'b0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push_fire - pop_fire;
            // sticky until the cpu reads a code
            if (pop_fire) begin
                kb_overflow <= 1'b0;
            end else if (key_strobe && full) begin
                kb_overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pipeline) begin
        if (push_fire) begin
            codes[wr_ptr] <= key_code;
        end
    end

endmodule

//--- logic/mmio_bridge.sv
module mmio_bridge (
    input  logic                  clk_pipeline,
    input  logic                  rst,
    input  logic                  ps2_clk,
    input  logic                  ps2_data,
    input  mmio_pkg::dmem_req_t   dmem,
    input  logic [29:0]           instr_addr,
    input  logic [31:0]           dc_rdata,
    input  logic [31:0]           ic_rdata,
    input  logic                  cache_stall,
    input  logic                  display_take,
    output mmio_pkg::dcache_req_t dcache,
    output logic                  ic_read,
    output logic [31:0]           dmem_rdata,
    output logic [31:0]           instr_rdata,
    output logic                  mem_stall,
    output logic                  trap_stall,
    output mmio_pkg::char_req_t   char_head,
    output logic                  char_valid,
    output logic                  kb_ready,
    output logic                  kb_overflow
);

    logic [31:0]         loader_rdata;
    logic [31:0]         loader_irdata;
    logic [3:0]          loader_wen;
    logic                char_push;
    logic                char_full;
    mmio_pkg::char_req_t char_req;
    logic                key_strobe;
    logic [7:0]          key_code;
    logic [7:0]          key_head;
    logic                key_pop;

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////////////////////

    mmio_decoder mmio_decoder_i (
        .dmem          (dmem),
        .instr_addr    (instr_addr),
        .dc_rdata      (dc_rdata),
        .ic_rdata      (ic_rdata),
        .loader_rdata  (loader_rdata),
        .loader_irdata (loader_irdata),
        .key_head      (key_head),
        .kb_ready      (kb_ready),
        .char_full     (char_full),
        .cache_stall   (cache_stall),
        .dcache        (dcache),
        .ic_read       (ic_read),
        .loader_wen    (loader_wen),
        .char_push     (char_push),
        .char_req      (char_req),
        .key_pop       (key_pop),
        .trap_stall    (trap_stall),
        .mem_stall     (mem_stall),
        .dmem_rdata    (dmem_rdata),
        .instr_rdata   (instr_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // devices
    ////////////////////////////////////////////////////////////////////////////

    // port a data, port b instruction fetch
    loader_ram loader_ram_i (
        .clk_pipeline (clk_pipeline),
        .a_addr       (dmem.addr.dev.word[mmio_pkg::loader_aw-1:0]),
        .a_wdata      (dmem.wdata),
        .a_wen        (loader_wen),
        .a_rdata      (loader_rdata),
        .b_addr       (instr_addr[mmio_pkg::loader_aw-1:0]),
        .b_rdata      (loader_irdata)
    );

    char_request_queue char_request_queue_i (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .push         (char_push),
        .push_req     (char_req),
        .full         (char_full),
        .take         (display_take),
        .head         (char_head),
        .valid        (char_valid)
    );

    ps2_receiver ps2_receiver_i (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .key_strobe   (key_strobe),
        .key_code     (key_code)
    );

    scancode_queue scancode_queue_i (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .key_strobe   (key_strobe),
        .key_code     (key_code),
        .pop          (key_pop),
        .head         (key_head),
        .kb_ready     (kb_ready),
        .kb_overflow  (kb_overflow)
    );

endmodule

//--- tests/ps2_host_model.sv
module ps2_host_model (
    input  logic clk_pipeline,
    output logic ps2_clk,
    output logic ps2_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // pipeline cycles per half period of the ps2 clock
    localparam int half_period = 8;

    // both lines idle high
    initial begin
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
    end

    // one frame, lsb first, data changes while the clock is high
    task automatic send_frame(input logic [7:0] code, input logic good_parity);
        logic [10:0] bits;
        logic        parity;
        parity = good_parity ? ~^code : ^code;
        bits   = {1'b1, parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk_pipeline);
            ps2_data <= bits[i];
            repeat (half_period) @(posedge clk_pipeline);
            ps2_clk <= 1'b0;
            repeat (half_period) @(posedge clk_pipeline);
            ps2_clk <= 1'b1;
        end
        // gap before the next frame
        repeat (half_period) @(posedge clk_pipeline);
    endtask

endmodule

//--- tests/tb_mmio_bridge.sv
module tb_mmio_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 5;
    localparam int cache_tests  = 24;
    localparam int frame_cycles = 11 * 17 + 16;
    localparam int test_cycles  = reset_cycles + cache_tests + 16 * 4 + 80
                                + 11 * frame_cycles + 60 + 10;
    localparam int cycle_limit  = 2 * test_cycles;

    logic                  clk_pipeline;
    logic                  rst;
    logic                  ps2_clk;
    logic                  ps2_data;
    mmio_pkg::dmem_req_t   dmem;
    logic [29:0]           instr_addr;
    logic [31:0]           dc_rdata;
    logic [31:0]           ic_rdata;
    logic                  cache_stall;
    logic                  display_take;
    mmio_pkg::dcache_req_t dcache;
    logic                  ic_read;
    logic [31:0]           dmem_rdata;
    logic [31:0]           instr_rdata;
    logic                  mem_stall;
    logic                  trap_stall;
    mmio_pkg::char_req_t   char_head;
    logic                  char_valid;
    logic                  kb_ready;
    logic                  kb_overflow;

    logic [31:0] seed;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    mmio_bridge mmio_bridge_i (.*);

    ps2_host_model ps2_host_model_i (.*);

    initial begin
        clk_pipeline = 1'b0;
        forever #10 clk_pipeline = ~clk_pipeline;
    end

    always @(posedge clk_pipeline) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout: the tests ran past %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers and expected values
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // single bytes and half words mirror, anything else writes the whole word
    function automatic logic [3:0] predict_wen(input logic [3:0] be);
        if (be inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100}) begin
            return {be[0], be[1], be[2], be[3]};
        end
        return 4'b1111;
    endfunction

    function automatic logic [31:0] predict_merge(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  wen);
        logic [31:0] w;
        w = old_word;
        for (int k = 0; k < 4; k++) begin
            if (wen[k]) begin
                w[8*k +: 8] = new_word[8*k +: 8];
            end
        end
        return w;
    endfunction

    function automatic mmio_pkg::char_req_t predict_char(input mmio_pkg::dmem_req_t r);
        mmio_pkg::char_req_t c;
        logic [1:0]          ofs;
        case (r.byte_en)
            4'b1000: ofs = 2'd0;
            4'b0100: ofs = 2'd1;
            4'b0010: ofs = 2'd2;
            default: ofs = 2'd3;
        endcase
        c.scroll = (r.addr.vmem.scroll == mmio_pkg::scroll_sel);
        c.addr   = {r.addr.vmem.char_word, ofs};
        c.ch     = r.wdata[8*ofs +: 8];
        return c;
    endfunction

    function automatic mmio_pkg::dmem_req_t display_write(input logic       scroll,
                                                          input logic [3:0] be);
        mmio_pkg::dmem_req_t r;
        r                  = '0;
        r.write            = 1'b1;
        r.byte_en          = be;
        r.wdata            = next_rand();
        r.addr.vmem.region = mmio_pkg::region_vmem;
        r.addr.vmem.scroll = scroll ? mmio_pkg::scroll_sel : 4'(next_rand() % 15);
        r.addr.vmem.pad    = 9'(next_rand());
        r.addr.vmem.char_word = 13'(next_rand());
        return r;
    endfunction

    function automatic mmio_pkg::dmem_req_t key_read();
        mmio_pkg::dmem_req_t r;
        r                 = '0;
        r.read            = 1'b1;
        r.addr.dev.region = mmio_pkg::region_kbd;
        return r;
    endfunction

    // drive on the rising edge, return at the falling edge to sample
    task automatic step(input mmio_pkg::dmem_req_t req, input logic [29:0] iaddr);
        @(posedge clk_pipeline);
        dmem       <= req;
        instr_addr <= iaddr;
        @(negedge clk_pipeline);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_char(input string name, input mmio_pkg::char_req_t got,
                              input mmio_pkg::char_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_dcache(input string name, input mmio_pkg::dcache_req_t got,
                                input mmio_pkg::dcache_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // head is checked, then popped with a one-cycle take
    task automatic take_and_check(input mmio_pkg::char_req_t exp);
        check_word("char_valid", 32'(char_valid), 32'd1);
        check_char("char_head", char_head, exp);
        @(posedge clk_pipeline);
        display_take <= 1'b1;
        @(posedge clk_pipeline);
        display_take <= 1'b0;
        @(negedge clk_pipeline);
    endtask

    task automatic wait_key_ready();
        int n;
        n = 0;
        while (!kb_ready && n < 16) begin
            @(negedge clk_pipeline);
            n++;
        end
        checks++;
        if (!kb_ready) begin
            errors++;
            $display("kb_ready never rose after a good frame was sent");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_cache_routing();
        mmio_pkg::dmem_req_t   req;
        mmio_pkg::dcache_req_t exp;
        logic [31:0]           r;
        logic [29:0]           iaddr;
        logic [31:0]           drd;
        logic [31:0]           ird;
        for (int i = 0; i < cache_tests; i++) begin
            r                 = next_rand();
            req               = '0;
            req.read          = r[0];
            req.write         = ~r[0];
            req.byte_en       = r[7:4];
            req.addr.dev.region = 4'(next_rand() % 12);
            req.addr.dev.sub  = 8'(next_rand());
            req.addr.dev.word = 18'(next_rand());
            req.wdata         = next_rand();
            iaddr             = 30'(next_rand());
            drd               = next_rand();
            ird               = next_rand();
            @(posedge clk_pipeline);
            dmem       <= req;
            instr_addr <= iaddr;
            dc_rdata   <= drd;
            ic_rdata   <= ird;
            @(negedge clk_pipeline);
            exp.read  = req.read;
            exp.write = req.write;
            exp.wen   = predict_wen(req.byte_en);
            exp.addr  = req.addr;
            exp.wdata = req.wdata;
            check_dcache("dcache", dcache, exp);
            check_word("dmem_rdata", dmem_rdata, drd);
            check_word("ic_read", 32'(ic_read),
                       32'(iaddr[29:26] != mmio_pkg::region_loader));
            if (iaddr[29:26] != mmio_pkg::region_loader) begin
                check_word("instr_rdata", instr_rdata, ird);
            end
        end
        step('0, '0);
    endtask

    // full word first, then a partial write over it
    task automatic test_loader_ram();
        mmio_pkg::dmem_req_t req;
        logic [12:0]         a;
        logic [31:0]         base;
        logic [31:0]         patt;
        logic [29:0]         iaddr;
        logic [31:0]         exp;
        for (int be = 0; be < 16; be++) begin
            a                   = 13'(next_rand());
            base                = next_rand();
            patt                = next_rand();
            iaddr               = {mmio_pkg::region_loader, 13'(next_rand()), a};
            req                 = '0;
            req.addr.dev.region = mmio_pkg::region_loader;
            req.addr.dev.sub    = 8'(next_rand());
            req.addr.dev.word   = {5'(next_rand()), a};
            req.write           = 1'b1;
            req.wdata           = base;
            req.byte_en         = 4'b1111;
            step(req, '0);
            req.wdata   = patt;
            req.byte_en = 4'(be);
            step(req, '0);
            req.write = 1'b0;
            req.read  = 1'b1;
            step(req, iaddr);
            step(req, iaddr);
            exp = predict_merge(base, patt, predict_wen(4'(be)));
            check_word("dmem_rdata", dmem_rdata, exp);
            check_word("instr_rdata", instr_rdata, exp);
            check_word("ic_read", 32'(ic_read), 32'd0);
        end
        step('0, '0);
    endtask

    task automatic test_display_queue();
        mmio_pkg::dmem_req_t req;
        mmio_pkg::char_req_t exp_q[$];
        // every one-hot lane, the last write asks for a scroll
        for (int i = 0; i < 5; i++) begin
            req = display_write(i == 4, 4'(4'b0001 << (i % 4)));
            exp_q.push_back(predict_char(req));
            step(req, '0);
            check_word("mem_stall", 32'(mem_stall), 32'd0);
        end
        step('0, '0);
        while (exp_q.size() > 0) begin
            take_and_check(exp_q.pop_front());
        end
        check_word("char_valid", 32'(char_valid), 32'd0);
        // back-pressure, the ninth write waits for a free entry
        for (int i = 0; i < 9; i++) begin
            req = display_write(1'b0, 4'(4'b1000 >> (i % 4)));
            exp_q.push_back(predict_char(req));
            step(req, '0);
            check_word("mem_stall", 32'(mem_stall), 32'(i == 8));
        end
        step(req, '0);
        check_word("mem_stall", 32'(mem_stall), 32'd1);
        take_and_check(exp_q.pop_front());
        check_word("mem_stall", 32'(mem_stall), 32'd0);
        step('0, '0);
        while (exp_q.size() > 0) begin
            take_and_check(exp_q.pop_front());
        end
        check_word("char_valid", 32'(char_valid), 32'd0);
    endtask

    task automatic test_keyboard();
        mmio_pkg::dmem_req_t req;
        logic [7:0]          code;
        req = key_read();
        step(req, '0);
        check_word("mem_stall", 32'(mem_stall), 32'd1);
        check_word("kb_ready", 32'(kb_ready), 32'd0);
        step('0, '0);
        code = 8'(next_rand());
        ps2_host_model_i.send_frame(code, 1'b1);
        wait_key_ready();
        step(req, '0);
        check_word("mem_stall", 32'(mem_stall), 32'd0);
        check_word("dmem_rdata", dmem_rdata, {24'd0, code});
        step('0, '0);
        check_word("kb_ready", 32'(kb_ready), 32'd0);
        // bad parity is dropped, well past the strobe window
        ps2_host_model_i.send_frame(8'(next_rand()), 1'b0);
        repeat (8) @(negedge clk_pipeline);
        check_word("kb_ready", 32'(kb_ready), 32'd0);
    endtask

    task automatic test_keyboard_overflow();
        mmio_pkg::dmem_req_t req;
        logic [7:0]          codes [9];
        for (int i = 0; i < 9; i++) begin
            codes[i] = 8'(next_rand());
            ps2_host_model_i.send_frame(codes[i], 1'b1);
        end
        @(negedge clk_pipeline);
        check_word("kb_overflow", 32'(kb_overflow), 32'd1);
        check_word("kb_ready", 32'(kb_ready), 32'd1);
        req = key_read();
        for (int i = 0; i < 8; i++) begin
            step(req, '0);
            check_word("dmem_rdata", dmem_rdata, {24'd0, codes[i]});
            check_word("mem_stall", 32'(mem_stall), 32'd0);
            check_word("kb_overflow", 32'(kb_overflow), 32'(i == 0));
        end
        step('0, '0);
        check_word("kb_ready", 32'(kb_ready), 32'd0);
        check_word("kb_overflow", 32'(kb_overflow), 32'd0);
    endtask

    task automatic test_trap_stall();
        mmio_pkg::dmem_req_t req;
        req                 = '0;
        req.read            = 1'b1;
        req.addr.dev.region = mmio_pkg::region_trap;
        req.addr.dev.sub    = mmio_pkg::trap_sub;
        req.addr.dev.word   = 18'(next_rand());
        step(req, '0);
        check_word("trap_stall", 32'(trap_stall), 32'd1);
        check_word("mem_stall", 32'(mem_stall), 32'd1);
        req.read  = 1'b0;
        req.write = 1'b1;
        req.wdata = next_rand();
        step(req, '0);
        check_word("trap_stall", 32'(trap_stall), 32'd1);
        check_word("mem_stall", 32'(mem_stall), 32'd1);
        // region d outside the trap sub field
        req.write        = 1'b0;
        req.read         = 1'b1;
        req.addr.dev.sub = 8'h5a;
        step(req, '0);
        check_word("dmem_rdata", dmem_rdata, 32'd0);
        check_word("trap_stall", 32'(trap_stall), 32'd0);
        check_word("mem_stall", 32'(mem_stall), 32'd0);
        step('0, '0);
        @(posedge clk_pipeline);
        cache_stall <= 1'b1;
        @(negedge clk_pipeline);
        check_word("mem_stall", 32'(mem_stall), 32'd1);
        @(posedge clk_pipeline);
        cache_stall <= 1'b0;
        @(negedge clk_pipeline);
        check_word("mem_stall", 32'(mem_stall), 32'd0);
    endtask

    initial begin
        seed         = 32'ha247_9c1f;
        rst          = 1'b0;
        dmem         = '0;
        instr_addr   = '0;
        dc_rdata     = '0;
        ic_rdata     = '0;
        cache_stall  = 1'b0;
        display_take = 1'b0;
        repeat (reset_cycles) @(posedge clk_pipeline);
        rst <= 1'b1;
        @(negedge clk_pipeline);
        check_word("char_valid", 32'(char_valid), 32'd0);
        check_word("kb_ready", 32'(kb_ready), 32'd0);
        check_word("kb_overflow", 32'(kb_overflow), 32'd0);
        test_cache_routing();
        test_loader_ram();
        test_display_queue();
        test_keyboard();
        test_keyboard_overflow();
        test_trap_stall();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
logic/mmio_pkg.sv
logic/mmio_decoder.sv
logic/loader_ram.sv
logic/char_request_queue.sv
logic/ps2_receiver.sv
logic/scancode_queue.sv
logic/mmio_bridge.sv
tests/ps2_host_model.sv
tests/tb_mmio_bridge.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the mmio bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_mmio_bridge -Mdir obj_dir -o sim_tb -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "no result line found in sim.log"
    exit 1
fi
exit 0
